// ==== rtl/decode_pkg.sv ====
// Shared types for the decode pipeline: widths, opcodes, operation classes,
// the instruction field layout and the decoded operation record.
// Every RTL module imports this package in its header.

package decode_pkg;

	// ========================================================================
	// Widths and fixed register numbers
	// ========================================================================
	parameter int xlen = 64;
	parameter int reg_w = 6;
	parameter int word_w = 32;

	// Architectural stack pointer and its banked copies at 43..46
	parameter logic [reg_w-1:0] sp_reg = 31;
	parameter logic [reg_w-1:0] sp_bank_base = 42;
	// Link registers 41..43 for lk 1..3
	parameter logic [reg_w-1:0] link_base = 40;

	// ========================================================================
	// Encodings
	// ========================================================================
	typedef enum logic [6:0] {
		R2   = 7'h02,
		ADDI = 7'h04,
		ANDI = 7'h08,
		ORI  = 7'h09,
		JMP  = 7'h20,
		EXI  = 7'h30,
		LDB  = 7'h40,
		LDBU = 7'h41,
		LDW  = 7'h42,
		LDWU = 7'h43,
		LDT  = 7'h44,
		LDTU = 7'h45,
		LDO  = 7'h46,
		STB  = 7'h50,
		STW  = 7'h51,
		STT  = 7'h52,
		STO  = 7'h53
	} opcode_e;

	typedef enum logic [2:0] {alu, alu_imm, load, store, jump, nop} op_class_e;

	typedef enum logic [1:0] {byt, wyde, tetra, octa} mem_size_e;

	// ========================================================================
	// Instruction field layout
	// ========================================================================
	typedef struct packed {
		logic [5:0] func;
		logic [3:0] rsvd;
		logic [4:0] rb;
		logic [4:0] ra;
		logic [4:0] rt;
		opcode_e    opcode;
	} r_fmt_t;

	// Immediate ops, loads and stores; rt holds the store source
	typedef struct packed {
		logic [14:0] imm;
		logic [4:0]  ra;
		logic [4:0]  rt;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [22:0] tgt;
		logic [1:0]  lk;
		opcode_e     opcode;
	} j_fmt_t;

	// Extension prefix, upper immediate bits
	typedef struct packed {
		logic [24:0] upper;
		opcode_e     opcode;
	} x_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
		x_fmt_t x;
	} instr_t;

	// Decoded operation as it travels down the pipeline
	typedef struct packed {
		op_class_e        op_class;
		logic [5:0]       func;
		logic [reg_w-1:0] ra;
		logic [reg_w-1:0] rb;
		logic [reg_w-1:0] rt;
		logic             rfwr;
		logic [xlen-1:0]  imm;
		mem_size_e        mem_size;
		logic             ldz;
	} decoded_op_t;

endpackage

// ==== rtl/imm_gen.sv ====
// Immediate builder for the decode stage.
// Pads the 15-bit field by opcode and widens it with a pending EXI prefix.

module imm_gen
	import decode_pkg::*;
(
	input  logic [word_w-1:0] word,
	input  logic [24:0]       prefix,
	input  logic              prefix_valid,
	output logic [xlen-1:0]   imm
);

	instr_t          iw;
	logic            has_field;
	logic [xlen-1:0] base;

	assign iw = word;

	always_comb
	begin
		has_field = 1'b1;
		case (iw.i.opcode)
			ADDI,
			LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO,
			STB, STW, STT, STO:
				base = {{(xlen-15){iw.i.imm[14]}}, iw.i.imm};
			// Mask style immediate, upper bits pass through the AND
			ANDI:
				base = {{(xlen-15){1'b1}}, iw.i.imm};
			ORI:
				base = {{(xlen-15){1'b0}}, iw.i.imm};
			JMP:
			begin
				has_field = 1'b0;
				base = {{(xlen-23){iw.j.tgt[22]}}, iw.j.tgt};
			end
			default:
			begin
				has_field = 1'b0;
				base = '0;
			end
		endcase

		// Prefix supplies bits 39:15, sign taken from its top bit
		if (prefix_valid && has_field)
			imm = {{(xlen-40){prefix[24]}}, prefix, iw.i.imm};
		else
			imm = base;
	end

endmodule

// ==== rtl/decode_stage.sv ====
// Front stage of the decode pipeline.
// Absorbs EXI prefix words and registers one decoded operation per
// instruction word, handing it on over a valid/ready stream.

module decode_stage
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  logic [word_w-1:0] in_word,
	output logic              in_ready,
	output logic              dec_valid,
	output decoded_op_t       dec_op,
	input  logic              dec_ready
);

	instr_t          iw;
	decoded_op_t     op_d;
	logic [24:0]     pfx_q;
	logic            pfx_v;
	logic [xlen-1:0] imm_d;
	logic            take_in;
	logic            is_prefix;

	assign iw = in_word;
	assign in_ready = !dec_valid || dec_ready;
	assign take_in = in_valid && in_ready;
	assign is_prefix = (iw.x.opcode == EXI);

	imm_gen u_imm (
		.word        (in_word),
		.prefix      (pfx_q),
		.prefix_valid(pfx_v),
		.imm         (imm_d)
	);

	// ========================================================================
	// Field decode
	// ========================================================================
	always_comb
	begin
		op_d = '0;
		op_d.op_class = nop;
		op_d.mem_size = octa;
		op_d.imm = imm_d;
		case (iw.r.opcode)
			R2:
			begin
				op_d.op_class = alu;
				op_d.func = iw.r.func;
				op_d.ra = reg_w'(iw.r.ra);
				op_d.rb = reg_w'(iw.r.rb);
				op_d.rt = reg_w'(iw.r.rt);
				op_d.rfwr = 1'b1;
			end
			ADDI, ANDI, ORI:
			begin
				op_d.op_class = alu_imm;
				op_d.ra = reg_w'(iw.i.ra);
				op_d.rt = reg_w'(iw.i.rt);
				op_d.rfwr = 1'b1;
			end
			LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO:
			begin
				op_d.op_class = load;
				op_d.ra = reg_w'(iw.i.ra);
				op_d.rt = reg_w'(iw.i.rt);
				op_d.rfwr = 1'b1;
			end
			// Store data register rides in rt, nothing is written back
			STB, STW, STT, STO:
			begin
				op_d.op_class = store;
				op_d.ra = reg_w'(iw.i.ra);
				op_d.rt = reg_w'(iw.i.rt);
			end
			JMP:
			begin
				op_d.op_class = jump;
				if (iw.j.lk != 2'd0)
				begin
					op_d.rt = link_base + reg_w'(iw.j.lk);
					op_d.rfwr = 1'b1;
				end
			end
			default:
				;
		endcase

		case (iw.r.opcode)
			LDB, LDBU, STB:   op_d.mem_size = byt;
			LDW, LDWU, STW:   op_d.mem_size = wyde;
			LDT, LDTU, STT:   op_d.mem_size = tetra;
			default:          op_d.mem_size = octa;
		endcase
		op_d.ldz = (iw.r.opcode inside {LDBU, LDWU, LDTU});
	end

	// ========================================================================
	// Control and output registers
	// ========================================================================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dec_valid <= 1'b0;
			pfx_v <= 1'b0;
		end
		else
		begin
			if (dec_valid && dec_ready)
				dec_valid <= 1'b0;
			if (take_in)
			begin
				if (is_prefix)
					pfx_v <= 1'b1;
				else
				begin
					dec_valid <= 1'b1;
					pfx_v <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_in && is_prefix)
			pfx_q <= iw.x.upper;
		if (take_in && !is_prefix)
			dec_op <= op_d;
	end

	// Stalled output keeps both its valid and its payload
	a_dec_hold: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_op));

endmodule

// ==== rtl/decode_fifo.sv ====
// Circular buffer of decoded operations between decode and remap.
// Depth comes from the top level; ready drops only when full.

module decode_fifo
	import decode_pkg::*;
#(
	parameter int depth = 4
)
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        wr_valid,
	input  decoded_op_t wr_op,
	output logic        wr_ready,
	output logic        rd_valid,
	output decoded_op_t rd_op,
	input  logic        rd_ready
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	decoded_op_t   mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic          do_wr;
	logic          do_rd;

	assign wr_ready = (count != cw'(depth));
	assign rd_valid = (count != '0);
	assign rd_op = mem[rd_ptr];
	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_op;
	end

	a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
		count <= cw'(depth));

endmodule

// ==== rtl/sp_remap_stage.sv ====
// Output stage of the decode pipeline.
// Swaps register 31 for the banked stack pointer picked by sp_sel (1..4)
// and registers the operation toward the consumer.

module sp_remap_stage
	import decode_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        op_valid,
	input  decoded_op_t op_in,
	output logic        op_ready,
	input  logic [2:0]  sp_sel,
	output logic        out_valid,
	output decoded_op_t out_op,
	input  logic        out_ready
);

	decoded_op_t op_m;
	logic        take;

	function automatic logic [reg_w-1:0] bank_reg(input logic [reg_w-1:0] r,
		input logic [2:0] sel);
		logic [reg_w-1:0] res;
		res = r;
		if (r == sp_reg && sel >= 3'd1 && sel <= 3'd4)
			res = sp_bank_base + reg_w'(sel);
		return res;
	endfunction

	assign op_ready = !out_valid || out_ready;
	assign take = op_valid && op_ready;

	always_comb
	begin
		op_m = op_in;
		op_m.ra = bank_reg(op_in.ra, sp_sel);
		op_m.rb = bank_reg(op_in.rb, sp_sel);
		op_m.rt = bank_reg(op_in.rt, sp_sel);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (take)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
			out_op <= op_m;
	end

endmodule

// ==== rtl/decode_unit_top.sv ====
// Decode unit: decode stage, operation FIFO and stack-pointer remap stage
// chained by valid/ready streams. Words in at the front, operations out.

module decode_unit_top
	import decode_pkg::*;
#(
	parameter int fifo_depth = 4
)
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  logic [word_w-1:0] in_word,
	output logic              in_ready,
	input  logic [2:0]        sp_sel,
	output logic              out_valid,
	output decoded_op_t       out_op,
	input  logic              out_ready
);

	logic        dec_valid;
	logic        dec_ready;
	decoded_op_t dec_op;
	logic        fifo_valid;
	logic        fifo_ready;
	decoded_op_t fifo_op;

	decode_stage u_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_word  (in_word),
		.in_ready (in_ready),
		.dec_valid(dec_valid),
		.dec_op   (dec_op),
		.dec_ready(dec_ready)
	);

	decode_fifo #(
		.depth(fifo_depth)
	) u_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_valid(dec_valid),
		.wr_op   (dec_op),
		.wr_ready(dec_ready),
		.rd_valid(fifo_valid),
		.rd_op   (fifo_op),
		.rd_ready(fifo_ready)
	);

	sp_remap_stage u_remap (
		.clk      (clk),
		.arst_n   (arst_n),
		.op_valid (fifo_valid),
		.op_in    (fifo_op),
		.op_ready (fifo_ready),
		.sp_sel   (sp_sel),
		.out_valid(out_valid),
		.out_op   (out_op),
		.out_ready(out_ready)
	);

endmodule

// ==== include/decode_model.svh ====
// Reference model of decode and stack-pointer remap for the testbench.
// Include inside a module; model_decode takes a word and its prefix state.

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic decode_pkg::decoded_op_t model_decode(input logic [31:0] w,
	input logic [24:0] pfx, input bit pfx_v);
	decode_pkg::decoded_op_t d;
	logic [6:0]  opc;
	logic [63:0] imm15;
	opc = w[6:0];
	d = '0;
	d.op_class = decode_pkg::nop;
	d.mem_size = decode_pkg::octa;
	imm15 = {{49{w[31]}}, w[31:17]};
	if (opc == decode_pkg::ANDI)
		imm15[63:15] = '1;
	if (opc == decode_pkg::ORI)
		imm15[63:15] = '0;
	if (pfx_v)
		imm15 = {{24{pfx[24]}}, pfx, w[31:17]};
	case (opc)
		decode_pkg::R2:
		begin
			d.op_class = decode_pkg::alu;
			d.func = w[31:26];
			d.ra = {1'b0, w[16:12]};
			d.rb = {1'b0, w[21:17]};
			d.rt = {1'b0, w[11:7]};
			d.rfwr = 1'b1;
		end
		decode_pkg::ADDI, decode_pkg::ANDI, decode_pkg::ORI:
		begin
			d.op_class = decode_pkg::alu_imm;
			d.ra = {1'b0, w[16:12]};
			d.rt = {1'b0, w[11:7]};
			d.rfwr = 1'b1;
			d.imm = imm15;
		end
		decode_pkg::LDB, decode_pkg::LDBU, decode_pkg::LDW, decode_pkg::LDWU,
		decode_pkg::LDT, decode_pkg::LDTU, decode_pkg::LDO,
		decode_pkg::STB, decode_pkg::STW, decode_pkg::STT, decode_pkg::STO:
		begin
			d.op_class = (opc >= 7'h50) ? decode_pkg::store : decode_pkg::load;
			d.ra = {1'b0, w[16:12]};
			d.rt = {1'b0, w[11:7]};
			d.rfwr = (opc < 7'h50);
			d.imm = imm15;
			d.ldz = (opc inside {decode_pkg::LDBU, decode_pkg::LDWU, decode_pkg::LDTU});
			// Size from the low opcode bits within each group
			if (opc >= 7'h50)
				d.mem_size = decode_pkg::mem_size_e'(opc[1:0]);
			else
				d.mem_size = decode_pkg::mem_size_e'(opc[2:1]);
		end
		decode_pkg::JMP:
		begin
			d.op_class = decode_pkg::jump;
			d.imm = {{41{w[31]}}, w[31:9]};
			if (w[8:7] != 2'd0)
			begin
				d.rt = 6'd40 + {4'd0, w[8:7]};
				d.rfwr = 1'b1;
			end
		end
		default:
			;
	endcase
	return d;
endfunction

function automatic decode_pkg::decoded_op_t model_remap(input decode_pkg::decoded_op_t op,
	input logic [2:0] sel);
	decode_pkg::decoded_op_t r;
	r = op;
	if (sel >= 3'd1 && sel <= 3'd4)
	begin
		if (op.ra == 6'd31)
			r.ra = 6'd42 + {3'd0, sel};
		if (op.rb == 6'd31)
			r.rb = 6'd42 + {3'd0, sel};
		if (op.rt == 6'd31)
			r.rt = 6'd42 + {3'd0, sel};
	end
	return r;
endfunction

`endif

// ==== sim/tb_decode_unit.sv ====
// Testbench for the decode unit pipeline.
// Drives random instruction words, predicts each operation with the
// reference model and checks every output transfer in order.

module tb_decode_unit
	import decode_pkg::*;
();

	localparam logic [31:0] seed = 32'hec1c_00e0;

	logic              clk;
	logic              arst_n;
	logic              in_valid;
	logic [word_w-1:0] in_word;
	logic              in_ready;
	logic [2:0]        sp_sel;
	logic              out_valid;
	decoded_op_t       out_op;
	logic              out_ready;

	logic [31:0] rng_state;
	logic [31:0] bp_state;
	bit          bp_en;
	decoded_op_t exp_q [$];
	logic [24:0] pfx_q;
	bit          pfx_v;
	int          mismatch_cnt;
	int          timeout_cnt;
	int          other_cnt;

	`include "decode_model.svh"

	decode_unit_top #(
		.fifo_depth(4)
	) uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_word  (in_word),
		.in_ready (in_ready),
		.sp_sel   (sp_sel),
		.out_valid(out_valid),
		.out_op   (out_op),
		.out_ready(out_ready)
	);

	always #20 clk = ~clk;

	// ========================================================================
	// Random numbers and word building
	// ========================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// Index 0..3 ALU, 4..14 memory, 15 jump, anything else illegal
	function automatic logic [6:0] pick_opcode(input logic [31:0] r, input int lo, input int n);
		int idx;
		idx = lo + int'(r[15:0]) % n;
		case (idx)
			0:       return R2;
			1:       return ADDI;
			2:       return ANDI;
			3:       return ORI;
			4:       return LDB;
			5:       return LDBU;
			6:       return LDW;
			7:       return LDWU;
			8:       return LDT;
			9:       return LDTU;
			10:      return LDO;
			11:      return STB;
			12:      return STW;
			13:      return STT;
			14:      return STO;
			15:      return JMP;
			default: return 7'h7f;
		endcase
	endfunction

	// Consumer side, ready toggles randomly when back-pressure is on
	always @(negedge clk)
	begin
		if (bp_en)
		begin
			bp_state = xorshift32(bp_state);
			out_ready = bp_state[7];
		end
		else
			out_ready = 1'b1;
	end

	// ========================================================================
	// Scoreboard
	// ========================================================================
	task automatic check_field(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (exp_v !== act_v)
		begin
			mismatch_cnt++;
			$display("[ERROR] %0t out_op.%s expected %h got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_output(input decoded_op_t act);
		decoded_op_t exp_op;
		if (exp_q.size() == 0)
		begin
			other_cnt++;
			$display("Output at %0t arrived with no operation pending", $time);
		end
		else
		begin
			exp_op = exp_q.pop_front();
			check_field("op_class", 64'(exp_op.op_class), 64'(act.op_class));
			check_field("func", 64'(exp_op.func), 64'(act.func));
			check_field("ra", 64'(exp_op.ra), 64'(act.ra));
			check_field("rb", 64'(exp_op.rb), 64'(act.rb));
			check_field("rt", 64'(exp_op.rt), 64'(act.rt));
			check_field("rfwr", 64'(exp_op.rfwr), 64'(act.rfwr));
			check_field("imm", exp_op.imm, act.imm);
			check_field("mem_size", 64'(exp_op.mem_size), 64'(act.mem_size));
			check_field("ldz", 64'(exp_op.ldz), 64'(act.ldz));
		end
	endtask

	// Prefix words only update the pending prefix
	task automatic track_input(input logic [31:0] w);
		if (w[6:0] == EXI)
		begin
			pfx_q = w[31:7];
			pfx_v = 1'b1;
		end
		else
		begin
			exp_q.push_back(model_remap(model_decode(w, pfx_q, pfx_v), sp_sel));
			pfx_v = 1'b0;
		end
	endtask

	always @(posedge clk)
	begin
		if (arst_n)
		begin
			if (out_valid && out_ready)
				check_output(out_op);
			if (in_valid && in_ready)
				track_input(in_word);
		end
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic send_word(input logic [31:0] w);
		logic [31:0] r;
		int          waited;
		bit          accepted;
		next_rand(r);
		if (r[1:0] == 2'b00)
		begin
			in_valid = 1'b0;
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_word = w;
		accepted = 1'b0;
		waited = 0;
		while (!accepted && waited < 100)
		begin
			@(posedge clk);
			accepted = in_ready;
			waited++;
		end
		if (!accepted)
		begin
			timeout_cnt++;
			$display("Timeout at %0t, in_ready stayed low for 100 cycles", $time);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			timeout_cnt++;
			$display("Timeout at %0t, %0d operations never came out", $time, exp_q.size());
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial
	begin
		logic [31:0] r;
		logic [31:0] w;
		logic [6:0]  opc;
		int          i;
		int          s;
		clk = 1'b0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		sp_sel = 3'd0;
		out_ready = 1'b1;
		bp_en = 1'b0;
		rng_state = seed;
		bp_state = seed ^ 32'h9e37_79b9;
		pfx_q = '0;
		pfx_v = 1'b0;
		mismatch_cnt = 0;
		timeout_cnt = 0;
		other_cnt = 0;

		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// Idle after reset
		@(negedge clk);
		if (out_valid !== 1'b0)
		begin
			mismatch_cnt++;
			$display("[ERROR] %0t out_valid expected 0 got %b", $time, out_valid);
		end
		if (in_ready !== 1'b1)
		begin
			mismatch_cnt++;
			$display("[ERROR] %0t in_ready expected 1 got %b", $time, in_ready);
		end

		// Register and immediate ALU forms
		for (i = 0; i < 40; i++)
		begin
			next_rand(r);
			opc = pick_opcode(r, 0, 4);
			next_rand(r);
			send_word({r[31:7], opc});
		end
		drain(400);

		// Loads and stores
		for (i = 0; i < 40; i++)
		begin
			next_rand(r);
			opc = pick_opcode(r, 4, 11);
			next_rand(r);
			send_word({r[31:7], opc});
		end
		drain(400);

		// Prefixed words, then plain jumps with every link field
		for (i = 0; i < 20; i++)
		begin
			next_rand(r);
			send_word({r[31:7], EXI});
			next_rand(r);
			opc = pick_opcode(r, 0, 16);
			next_rand(r);
			send_word({r[31:7], opc});
		end
		for (i = 0; i < 16; i++)
		begin
			next_rand(r);
			send_word({r[31:9], i[1:0], JMP});
		end
		drain(400);

		// Stack pointer bank sweep
		for (s = 0; s < 8; s++)
		begin
			sp_sel = s[2:0];
			for (i = 0; i < 12; i++)
			begin
				next_rand(r);
				opc = pick_opcode(r, 0, 16);
				next_rand(r);
				w = {r[31:7], opc};
				next_rand(r);
				if (r[0])
					w[16:12] = 5'd31;
				if (r[1])
					w[21:17] = 5'd31;
				if (r[2])
					w[11:7] = 5'd31;
				send_word(w);
			end
			drain(400);
		end

		// Mixed traffic under back-pressure
		sp_sel = 3'd2;
		bp_en = 1'b1;
		for (i = 0; i < 60; i++)
		begin
			next_rand(r);
			if (r[3:0] == 4'd0)
			begin
				next_rand(r);
				send_word({r[31:7], EXI});
			end
			next_rand(r);
			opc = pick_opcode(r, 0, 17);
			next_rand(r);
			send_word({r[31:7], opc});
		end
		drain(1000);
		bp_en = 1'b0;

		// Idle window, a repeated or stray operation shows up here
		repeat (20) @(negedge clk);

		$display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatch_cnt,
			timeout_cnt, other_cnt);
		if (mismatch_cnt + timeout_cnt + other_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/decode_stage.sv
rtl/decode_fifo.sv
rtl/sp_remap_stage.sv
rtl/decode_unit_top.sv
sim/tb_decode_unit.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - files:
      - rtl/decode_pkg.sv
      - rtl/imm_gen.sv
      - rtl/decode_stage.sv
      - rtl/decode_fifo.sv
      - rtl/sp_remap_stage.sv
      - rtl/decode_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_decode_unit.sv
